/* src/schedulerPkg.sv */
// ********************
// Scheduler package
// Lane counts, issue-to-wakeup latencies, pointer types and the wakeup
// pipeline entry shared by the wakeup pipeline register
// ********************

`default_nettype none

package schedulerPkg;

    // Lane counts in slot order of integer, complex, load and store
    localparam int IntIssueWidth = 2;
    localparam int ComplexIssueWidth = 1;
    localparam int LoadIssueWidth = 1;
    localparam int StoreIssueWidth = 1;
    localparam int MemIssueWidth = LoadIssueWidth + StoreIssueWidth;
    localparam int IssueWidth = IntIssueWidth + ComplexIssueWidth + MemIssueWidth;

    // Store lanes never wake up register consumers
    localparam int WakeupWidth = IntIssueWidth + ComplexIssueWidth + LoadIssueWidth;

    // Issue-to-wakeup latency per lane class
    localparam int IntLatency = 2;
    localparam int ComplexLatency = 3;
    localparam int MemLatency = 2;
    localparam int MaxLatency =
        (IntLatency > ComplexLatency) ?
            ((IntLatency > MemLatency) ? IntLatency : MemLatency) :
            ((ComplexLatency > MemLatency) ? ComplexLatency : MemLatency);

    localparam int IssueQueueEntries = 16;
    localparam int ActiveListEntries = 32;

    typedef logic [$clog2(IssueQueueEntries)-1:0] IqIndex;
    typedef logic [IssueQueueEntries-1:0] IqOneHot;
    typedef logic [$clog2(ActiveListEntries)-1:0] ActiveListIndex;
    typedef logic [$clog2(MaxLatency+1)-1:0] WindowCount;

    // One stage of a lane delay line
    typedef struct packed {
        logic valid;
        IqIndex ptr;
        IqOneHot vector;
        ActiveListIndex activeListPtr;
    } WakeupPipeEntry;

    // Head equal to tail means an empty range
    function automatic logic activeListPtrInRange(
        input ActiveListIndex ptr,
        input ActiveListIndex head,
        input ActiveListIndex tail
    );
        logic inRange;
        if (head < tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else if (tail < head) begin
            // Range wraps around the end of the active list
            inRange = (ptr >= head) || (ptr < tail);
        end else begin
            inRange = 1'b0;
        end
        return inRange;
    endfunction

endpackage

`default_nettype wire

/* src/wakeupPipeLane.sv */
// ********************
// Wakeup pipe lane
// Delay line of issued ops for one issue lane, with entry masking,
// full clear, stall hold and selective wakeup suppression at the head
// ********************

`timescale 1ns/10ps
`default_nettype none

module wakeupPipeLane #(
    parameter int Latency = 2
) (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        stall,
    input  wire logic                        toRecoveryPhase,
    input  wire logic                        recoveryFromRwStage,
    input  wire logic                        selected,
    input  wire schedulerPkg::IqIndex         selectedPtr,
    input  wire schedulerPkg::IqOneHot        selectedVector,
    input  wire schedulerPkg::ActiveListIndex selectedActiveListPtr,
    input  wire schedulerPkg::IqOneHot        flushIqEntry,
    input  wire logic                        windowActive,
    input  wire schedulerPkg::ActiveListIndex flushHeadPtr,
    input  wire schedulerPkg::ActiveListIndex flushTailPtr,
    output logic                             wakeup,
    output schedulerPkg::IqIndex              wakeupPtr,
    output schedulerPkg::IqOneHot             wakeupVector,
    output logic                             releaseEntry,
    output schedulerPkg::IqIndex              releasePtr
);

    // Stage 0 is the head and new ops enter at the tail stage
    localparam int TailStage = Latency - 1;

    schedulerPkg::WakeupPipeEntry stage [Latency];
    schedulerPkg::WakeupPipeEntry nextEntry;
    logic fullRecovery;
    logic headFlushed;

    assign fullRecovery = toRecoveryPhase && !recoveryFromRwStage;

    // Drop the op if its own issue queue entry is being flushed
    always_comb begin
        nextEntry.valid = selected && !flushIqEntry[selectedPtr];
        nextEntry.ptr = selectedPtr;
        nextEntry.vector = selectedVector;
        nextEntry.activeListPtr = selectedActiveListPtr;
    end

    // Shift on advancing edges and drop every op on a full recovery
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < Latency; i++) begin
                stage[i].valid <= 1'b0;
            end
        end else if (fullRecovery) begin
            // Clears even under stall
            for (int i = 0; i < Latency; i++) begin
                stage[i].valid <= 1'b0;
            end
        end else if (!stall) begin
            for (int i = 1; i < Latency; i++) begin
                stage[i-1] <= stage[i];
            end
            stage[TailStage] <= nextEntry;
        end
    end

    // Head op belongs to the flushed range of a recent selective recovery
    assign headFlushed = windowActive &&
        schedulerPkg::activeListPtrInRange(stage[0].activeListPtr, flushHeadPtr, flushTailPtr);

    assign wakeup = stage[0].valid && !headFlushed;
    assign wakeupPtr = stage[0].ptr;
    assign wakeupVector = stage[0].vector;

    // Flushed ops still free their entry and only lose the wakeup
    assign releaseEntry = stage[0].valid && !stall;
    assign releasePtr = stage[0].ptr;

endmodule

`default_nettype wire

/* src/flushWindowTracker.sv */
// ********************
// Flush window tracker
// Holds the flushed active-list range and per-class countdowns that
// mark when flushed ops may still sit in the lanes
// ********************

`timescale 1ns/10ps
`default_nettype none

module flushWindowTracker (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        stall,
    input  wire logic                        toRecoveryPhase,
    input  wire logic                        recoveryFromRwStage,
    input  wire schedulerPkg::ActiveListIndex flushRangeHeadPtr,
    input  wire schedulerPkg::ActiveListIndex flushRangeTailPtr,
    output logic                             intWindowActive,
    output logic                             complexWindowActive,
    output logic                             memWindowActive,
    output schedulerPkg::ActiveListIndex      flushHeadPtr,
    output schedulerPkg::ActiveListIndex      flushTailPtr,
    output logic                             flushedOpExist
);

    localparam int ClassCount = 3;
    localparam int IntClass = 0;
    localparam int ComplexClass = 1;
    localparam int MemClass = 2;

    // Each class must drain its whole lane depth
    localparam schedulerPkg::WindowCount LoadValue [ClassCount] = '{
        schedulerPkg::WindowCount'(schedulerPkg::IntLatency),
        schedulerPkg::WindowCount'(schedulerPkg::ComplexLatency),
        schedulerPkg::WindowCount'(schedulerPkg::MemLatency)
    };

    schedulerPkg::WindowCount windowCount [ClassCount];
    logic selectiveRecovery;

    assign selectiveRecovery = toRecoveryPhase && recoveryFromRwStage;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int c = 0; c < ClassCount; c++) begin
                windowCount[c] <= '0;
            end
        end else if (selectiveRecovery) begin
            for (int c = 0; c < ClassCount; c++) begin
                windowCount[c] <= LoadValue[c];
            end
        end else if (!stall) begin
            // Count one lane stage per advance
            for (int c = 0; c < ClassCount; c++) begin
                if (windowCount[c] != '0) begin
                    windowCount[c] <= windowCount[c] - 1'b1;
                end
            end
        end
    end

    // Flushed range of the latest selective recovery
    always_ff @(posedge clk) begin
        if (selectiveRecovery) begin
            flushHeadPtr <= flushRangeHeadPtr;
            flushTailPtr <= flushRangeTailPtr;
        end
    end

    assign intWindowActive = windowCount[IntClass] != '0;
    assign complexWindowActive = windowCount[ComplexClass] != '0;
    assign memWindowActive = windowCount[MemClass] != '0;

    assign flushedOpExist = intWindowActive || complexWindowActive || memWindowActive;

endmodule

`default_nettype wire

/* src/wakeupPipelineRegister.sv */
// ********************
// Wakeup pipeline register
// Tracks issued ops per lane and maps lane heads to the wakeup,
// store-wakeup and issue queue release slots
// ********************

`timescale 1ns/10ps
`default_nettype none

module wakeupPipelineRegister (
    input  wire logic                        clk,
    input  wire logic                        rstN,
    input  wire logic                        selected [schedulerPkg::IssueWidth],
    input  wire schedulerPkg::IqIndex         selectedPtr [schedulerPkg::IssueWidth],
    input  wire schedulerPkg::IqOneHot        selectedVector [schedulerPkg::IssueWidth],
    input  wire schedulerPkg::ActiveListIndex selectedActiveListPtr [schedulerPkg::IssueWidth],
    input  wire schedulerPkg::IqOneHot        flushIqEntry,
    input  wire logic                        stall,
    input  wire logic                        toRecoveryPhase,
    input  wire logic                        recoveryFromRwStage,
    input  wire schedulerPkg::ActiveListIndex flushRangeHeadPtr,
    input  wire schedulerPkg::ActiveListIndex flushRangeTailPtr,
    output logic                             wakeup [schedulerPkg::WakeupWidth],
    output schedulerPkg::IqIndex
        wakeupPtr [schedulerPkg::WakeupWidth + schedulerPkg::StoreIssueWidth],
    output schedulerPkg::IqOneHot
        wakeupVector [schedulerPkg::WakeupWidth + schedulerPkg::StoreIssueWidth],
    output logic                             releaseEntry [schedulerPkg::IssueWidth],
    output schedulerPkg::IqIndex              releasePtr [schedulerPkg::IssueWidth],
    output logic                             flushedOpExist
);

    // First lane index of each class
    localparam int ComplexBase = schedulerPkg::IntIssueWidth;
    localparam int LoadBase = ComplexBase + schedulerPkg::ComplexIssueWidth;
    localparam int StoreBase = LoadBase + schedulerPkg::LoadIssueWidth;

    logic intWindowActive;
    logic complexWindowActive;
    logic memWindowActive;
    schedulerPkg::ActiveListIndex flushHeadPtr;
    schedulerPkg::ActiveListIndex flushTailPtr;

    flushWindowTracker tracker (
        .clk                 (clk),
        .rstN                (rstN),
        .stall               (stall),
        .toRecoveryPhase     (toRecoveryPhase),
        .recoveryFromRwStage (recoveryFromRwStage),
        .flushRangeHeadPtr   (flushRangeHeadPtr),
        .flushRangeTailPtr   (flushRangeTailPtr),
        .intWindowActive     (intWindowActive),
        .complexWindowActive (complexWindowActive),
        .memWindowActive     (memWindowActive),
        .flushHeadPtr        (flushHeadPtr),
        .flushTailPtr        (flushTailPtr),
        .flushedOpExist      (flushedOpExist)
    );

    for (genvar i = 0; i < schedulerPkg::IntIssueWidth; i++) begin : gIntLane
        wakeupPipeLane #(.Latency(schedulerPkg::IntLatency)) lane (
            .clk(clk), .rstN(rstN), .stall(stall),
            .toRecoveryPhase(toRecoveryPhase), .recoveryFromRwStage(recoveryFromRwStage),
            .selected(selected[i]), .selectedPtr(selectedPtr[i]),
            .selectedVector(selectedVector[i]),
            .selectedActiveListPtr(selectedActiveListPtr[i]),
            .flushIqEntry(flushIqEntry), .windowActive(intWindowActive),
            .flushHeadPtr(flushHeadPtr), .flushTailPtr(flushTailPtr),
            .wakeup(wakeup[i]), .wakeupPtr(wakeupPtr[i]), .wakeupVector(wakeupVector[i]),
            .releaseEntry(releaseEntry[i]), .releasePtr(releasePtr[i])
        );
    end

    for (genvar i = ComplexBase; i < LoadBase; i++) begin : gComplexLane
        wakeupPipeLane #(.Latency(schedulerPkg::ComplexLatency)) lane (
            .clk(clk), .rstN(rstN), .stall(stall),
            .toRecoveryPhase(toRecoveryPhase), .recoveryFromRwStage(recoveryFromRwStage),
            .selected(selected[i]), .selectedPtr(selectedPtr[i]),
            .selectedVector(selectedVector[i]),
            .selectedActiveListPtr(selectedActiveListPtr[i]),
            .flushIqEntry(flushIqEntry), .windowActive(complexWindowActive),
            .flushHeadPtr(flushHeadPtr), .flushTailPtr(flushTailPtr),
            .wakeup(wakeup[i]), .wakeupPtr(wakeupPtr[i]), .wakeupVector(wakeupVector[i]),
            .releaseEntry(releaseEntry[i]), .releasePtr(releasePtr[i])
        );
    end

    for (genvar i = LoadBase; i < StoreBase; i++) begin : gLoadLane
        wakeupPipeLane #(.Latency(schedulerPkg::MemLatency)) lane (
            .clk(clk), .rstN(rstN), .stall(stall),
            .toRecoveryPhase(toRecoveryPhase), .recoveryFromRwStage(recoveryFromRwStage),
            .selected(selected[i]), .selectedPtr(selectedPtr[i]),
            .selectedVector(selectedVector[i]),
            .selectedActiveListPtr(selectedActiveListPtr[i]),
            .flushIqEntry(flushIqEntry), .windowActive(memWindowActive),
            .flushHeadPtr(flushHeadPtr), .flushTailPtr(flushTailPtr),
            .wakeup(wakeup[i]), .wakeupPtr(wakeupPtr[i]), .wakeupVector(wakeupVector[i]),
            .releaseEntry(releaseEntry[i]), .releasePtr(releasePtr[i])
        );
    end

    // Store heads only feed the store-wakeup slots past the register wakeups
    for (genvar i = 0; i < schedulerPkg::StoreIssueWidth; i++) begin : gStoreLane
        wakeupPipeLane #(.Latency(schedulerPkg::MemLatency)) lane (
            .clk(clk), .rstN(rstN), .stall(stall),
            .toRecoveryPhase(toRecoveryPhase), .recoveryFromRwStage(recoveryFromRwStage),
            .selected(selected[StoreBase+i]), .selectedPtr(selectedPtr[StoreBase+i]),
            .selectedVector(selectedVector[StoreBase+i]),
            .selectedActiveListPtr(selectedActiveListPtr[StoreBase+i]),
            .flushIqEntry(flushIqEntry), .windowActive(memWindowActive),
            .flushHeadPtr(flushHeadPtr), .flushTailPtr(flushTailPtr),
            .wakeup(),
            .wakeupPtr(wakeupPtr[schedulerPkg::WakeupWidth+i]),
            .wakeupVector(wakeupVector[schedulerPkg::WakeupWidth+i]),
            .releaseEntry(releaseEntry[StoreBase+i]), .releasePtr(releasePtr[StoreBase+i])
        );
    end

endmodule

`default_nettype wire

/* verif/tbClockGen.sv */
// ********************
// Testbench clock and reset
// 4 ns clock, reset held low for two cycles
// ********************

`timescale 1ns/10ps
`default_nettype none

module tbClockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release on a falling edge away from the sampling edge
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/wakeupPipelineTb.sv */
// ********************
// Wakeup pipeline register testbench
// Random and directed traffic against a per-lane model checked every cycle
// ********************

`timescale 1ns/10ps
`default_nettype none

module wakeupPipelineTb;

    logic clk;
    logic rstN;
    logic selected [schedulerPkg::IssueWidth];
    schedulerPkg::IqIndex selectedPtr [schedulerPkg::IssueWidth];
    schedulerPkg::IqOneHot selectedVector [schedulerPkg::IssueWidth];
    schedulerPkg::ActiveListIndex selectedActiveListPtr [schedulerPkg::IssueWidth];
    schedulerPkg::IqOneHot flushIqEntry;
    logic stall;
    logic toRecoveryPhase;
    logic recoveryFromRwStage;
    schedulerPkg::ActiveListIndex flushRangeHeadPtr;
    schedulerPkg::ActiveListIndex flushRangeTailPtr;
    logic wakeup [schedulerPkg::WakeupWidth];
    schedulerPkg::IqIndex wakeupPtr [schedulerPkg::IssueWidth];
    schedulerPkg::IqOneHot wakeupVector [schedulerPkg::IssueWidth];
    logic releaseEntry [schedulerPkg::IssueWidth];
    schedulerPkg::IqIndex releasePtr [schedulerPkg::IssueWidth];
    logic flushedOpExist;

    // Lane model with the head op at index 0
    schedulerPkg::WakeupPipeEntry laneModel [schedulerPkg::IssueWidth][schedulerPkg::MaxLatency];
    int windowCount [3];
    schedulerPkg::ActiveListIndex rangeHead;
    schedulerPkg::ActiveListIndex rangeTail;
    int seed;
    int checkCount;
    int errorCount;
    int timeoutCount;

    tbClockGen clockGen (.clk(clk), .rstN(rstN));

    wakeupPipelineRegister uut (
        .clk(clk), .rstN(rstN), .selected(selected), .selectedPtr(selectedPtr),
        .selectedVector(selectedVector), .selectedActiveListPtr(selectedActiveListPtr),
        .flushIqEntry(flushIqEntry), .stall(stall), .toRecoveryPhase(toRecoveryPhase),
        .recoveryFromRwStage(recoveryFromRwStage), .flushRangeHeadPtr(flushRangeHeadPtr),
        .flushRangeTailPtr(flushRangeTailPtr), .wakeup(wakeup), .wakeupPtr(wakeupPtr),
        .wakeupVector(wakeupVector), .releaseEntry(releaseEntry), .releasePtr(releasePtr),
        .flushedOpExist(flushedOpExist)
    );

    // Class 0 integer, 1 complex, 2 memory
    function automatic int laneClass(input int lane);
        if (lane < schedulerPkg::IntIssueWidth) return 0;
        if (lane < schedulerPkg::IntIssueWidth + schedulerPkg::ComplexIssueWidth) return 1;
        return 2;
    endfunction

    function automatic int classLatency(input int cls);
        case (cls)
            0: return schedulerPkg::IntLatency;
            1: return schedulerPkg::ComplexLatency;
            default: return schedulerPkg::MemLatency;
        endcase
    endfunction

    // Distance from the range head, taken modulo the active list size
    function automatic logic inFlushedRange(input schedulerPkg::ActiveListIndex ptr);
        schedulerPkg::ActiveListIndex offset;
        schedulerPkg::ActiveListIndex span;
        offset = ptr - rangeHead;
        span = rangeTail - rangeHead;
        return offset < span;
    endfunction

    function automatic logic predictWakeup(input int lane);
        schedulerPkg::WakeupPipeEntry head;
        head = laneModel[lane][0];
        if (windowCount[laneClass(lane)] != 0 && inFlushedRange(head.activeListPtr)) return 1'b0;
        return head.valid;
    endfunction

    function automatic int randomBelow(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compareOutputs();
        schedulerPkg::WakeupPipeEntry head;
        for (int l = 0; l < schedulerPkg::WakeupWidth; l++) begin
            checkValue($sformatf("wakeup[%0d]", l), predictWakeup(l), wakeup[l]);
        end
        // Lane order equals slot order, so the store lane owns the last pointer slot
        for (int l = 0; l < schedulerPkg::IssueWidth; l++) begin
            head = laneModel[l][0];
            checkValue($sformatf("releaseEntry[%0d]", l), head.valid && !stall, releaseEntry[l]);
            if (head.valid) begin
                checkValue($sformatf("wakeupPtr[%0d]", l), head.ptr, wakeupPtr[l]);
                checkValue($sformatf("wakeupVector[%0d]", l), head.vector, wakeupVector[l]);
                checkValue($sformatf("releasePtr[%0d]", l), head.ptr, releasePtr[l]);
            end
        end
        checkValue("flushedOpExist",
                   windowCount[0] != 0 || windowCount[1] != 0 || windowCount[2] != 0,
                   flushedOpExist);
    endtask

    task automatic advanceModel();
        schedulerPkg::WakeupPipeEntry incoming;
        int depth;
        for (int l = 0; l < schedulerPkg::IssueWidth; l++) begin
            depth = classLatency(laneClass(l));
            incoming.valid = selected[l] && !flushIqEntry[selectedPtr[l]];
            incoming.ptr = selectedPtr[l];
            incoming.vector = selectedVector[l];
            incoming.activeListPtr = selectedActiveListPtr[l];
            if (toRecoveryPhase && !recoveryFromRwStage) begin
                for (int s = 0; s < depth; s++) laneModel[l][s] = '0;
            end else if (!stall) begin
                for (int s = 0; s < depth - 1; s++) laneModel[l][s] = laneModel[l][s+1];
                laneModel[l][depth-1] = incoming;
            end
        end
        if (toRecoveryPhase && recoveryFromRwStage) begin
            for (int c = 0; c < 3; c++) windowCount[c] = classLatency(c);
            rangeHead = flushRangeHeadPtr;
            rangeTail = flushRangeTailPtr;
        end else if (!stall) begin
            for (int c = 0; c < 3; c++) if (windowCount[c] > 0) windowCount[c]--;
        end
    endtask

    // Compare before the edge takes effect and then step the model
    always @(posedge clk) begin
        if (!rstN) begin
            for (int l = 0; l < schedulerPkg::IssueWidth; l++) begin
                for (int s = 0; s < schedulerPkg::MaxLatency; s++) laneModel[l][s] = '0;
            end
            for (int c = 0; c < 3; c++) windowCount[c] = 0;
        end else begin
            compareOutputs();
            advanceModel();
        end
    end

    // Random ops on every lane where maskPct sets how often own entries get flushed
    task automatic driveTraffic(input int stallPct, input int maskPct);
        flushIqEntry = schedulerPkg::IqOneHot'($random(seed)) & 16'h0101;
        for (int l = 0; l < schedulerPkg::IssueWidth; l++) begin
            selected[l] = randomBelow(4) != 0;
            selectedPtr[l] = schedulerPkg::IqIndex'(randomBelow(16));
            selectedVector[l] = schedulerPkg::IqOneHot'(1) << selectedPtr[l];
            selectedActiveListPtr[l] = schedulerPkg::ActiveListIndex'(randomBelow(32));
            if (randomBelow(100) < maskPct) flushIqEntry[selectedPtr[l]] = 1'b1;
        end
        stall = randomBelow(100) < stallPct;
        toRecoveryPhase = 1'b0;
        recoveryFromRwStage = 1'b0;
    endtask

    task automatic runTraffic(input int cycles, input int stallPct, input int maskPct);
        repeat (cycles) begin
            @(negedge clk);
            driveTraffic(stallPct, maskPct);
        end
    endtask

    task automatic runRecovery(input logic fromRwStage, input logic stallHigh,
                               input schedulerPkg::ActiveListIndex head,
                               input schedulerPkg::ActiveListIndex tail);
        int edges;
        int cycles;
        logic stallDriven;
        runTraffic(4, 0, 0);
        @(negedge clk);
        driveTraffic(0, 0);
        stall = stallHigh;
        toRecoveryPhase = 1'b1;
        recoveryFromRwStage = fromRwStage;
        flushRangeHeadPtr = head;
        flushRangeTailPtr = tail;
        @(negedge clk);
        edges = 0;
        cycles = 0;
        // Window should close after MaxLatency unstalled edges
        while (fromRwStage && flushedOpExist && cycles < 30) begin
            driveTraffic(30, 0);
            stallDriven = stall;
            @(negedge clk);
            if (!stallDriven) edges++;
            cycles++;
        end
        if (flushedOpExist) begin
            timeoutCount++;
            $display("Timeout: flushedOpExist still high %0d cycles after recovery", cycles);
        end else if (fromRwStage && edges != schedulerPkg::MaxLatency) begin
            errorCount++;
            $display("ERR time %0t flushWindowEdges expected %0d actual %0d", $time,
                     schedulerPkg::MaxLatency, edges);
        end
        runTraffic(schedulerPkg::MaxLatency + 1, 0, 0);
    endtask

    initial begin
        int cycles;
        seed = 32'h37b5_5044;
        checkCount = 0;
        errorCount = 0;
        timeoutCount = 0;
        rangeHead = '0;
        rangeTail = '0;
        driveTraffic(0, 0);
        for (int l = 0; l < schedulerPkg::IssueWidth; l++) selected[l] = 1'b0;
        flushRangeHeadPtr = '0;
        flushRangeTailPtr = '0;
        cycles = 0;
        while (!rstN && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!rstN) begin
            timeoutCount++;
            $display("Timeout: reset was never released");
        end
        runTraffic(40, 0, 0);
        // Stall bursts of one to five cycles
        repeat (8) begin
            runTraffic(2, 0, 0);
            runTraffic(1 + randomBelow(5), 100, 0);
        end
        runTraffic(40, 20, 60);
        runRecovery(1'b0, 1'b0, '0, '0);
        runRecovery(1'b0, 1'b1, '0, '0);
        runRecovery(1'b1, 1'b0, 5'd4, 5'd20);
        runRecovery(1'b1, 1'b0, 5'd28, 5'd6);
        runRecovery(1'b1, 1'b1, 5'd10, 5'd10);
        runTraffic(30, 30, 20);
        @(negedge clk);
        driveTraffic(0, 0);
        for (int l = 0; l < schedulerPkg::IssueWidth; l++) selected[l] = 1'b0;
        repeat (schedulerPkg::MaxLatency + 2) @(negedge clk);
        $display("Checks %0d, mismatches %0d, timeouts %0d", checkCount, errorCount,
                 timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/schedulerPkg.sv
src/wakeupPipeLane.sv
src/flushWindowTracker.sv
src/wakeupPipelineRegister.sv
verif/tbClockGen.sv
verif/wakeupPipelineTb.sv

/* Bender.yml */
package:
  name: wakeup_pipeline_register

sources:
  - src/schedulerPkg.sv
  - src/wakeupPipeLane.sv
  - src/flushWindowTracker.sv
  - src/wakeupPipelineRegister.sv
  - target: test
    files:
      - verif/tbClockGen.sv
      - verif/wakeupPipelineTb.sv
